//--- include/tile_sprites.svh
/*
 * trail tile sprites, one 8-bit mask per row, bit 0 is the leftmost pixel
 */
`ifndef TILE_SPRITES_SVH
`define TILE_SPRITES_SVH

// straight run across the cell
localparam logic [7:0] SPRITE_HORIZ [8] = '{
	8'h00,
	8'h00,
	8'h00,
	8'hFF,
	8'hFF,
	8'h00,
	8'h00,
	8'h00
};

// straight run down the cell
localparam logic [7:0] SPRITE_VERT [8] = '{
	8'h18,
	8'h18,
	8'h18,
	8'h18,
	8'h18,
	8'h18,
	8'h18,
	8'h18
};

// turn, joins the top edge to the right edge
localparam logic [7:0] SPRITE_CORNER [8] = '{
	8'h18,
	8'h18,
	8'h18,
	8'hF8,
	8'hF8,
	8'h00,
	8'h00,
	8'h00
};

`endif

//--- verilog/arena_pkg.sv
/*
 * arena geometry for the light-cycle game: grid size, screen layout,
 * heading codes and the address types used by the trail block
 */
package arena_pkg;

	// playing field in cells and pixels
	localparam int GRID_CELLS = 32;
	localparam int CELL_PX = 8;

	// frame buffer packing, 640 pixels of 4 bits per line
	localparam int PX_PER_WORD = 4;
	localparam int WORDS_PER_ROW = 160;

	typedef logic [4:0] cell_t;
	typedef logic [1:0] dir_t;

	// heading codes as driven by the motion logic
	localparam dir_t DIR_UP = 2'd0;
	localparam dir_t DIR_DOWN = 2'd1;
	localparam dir_t DIR_LEFT = 2'd2;
	localparam dir_t DIR_RIGHT = 2'd3;

	// word address into the 640x480 frame buffer
	typedef logic [16:0] fb_addr_t;

	// arena placement on screen
	typedef logic [8:0] origin_row_t;
	typedef logic [7:0] origin_col_t;

endpackage

//--- verilog/trail_pkg.sv
/*
 * trail definitions: tile kinds, pixel colours, the frame buffer word
 * and the register map of the configuration block
 */
package trail_pkg;

	typedef logic [1:0] tile_kind_t;

	localparam tile_kind_t TILE_NONE = 2'd0;
	localparam tile_kind_t TILE_HORIZ = 2'd1;
	localparam tile_kind_t TILE_VERT = 2'd2;
	localparam tile_kind_t TILE_CORNER = 2'd3;

	typedef logic [3:0] colour_t;

	// one frame buffer word, pixel 0 sits in the low nibble
	typedef union packed {
		logic [15:0] raw;
		colour_t [3:0] px;
	} fb_word_u;

	typedef logic [1:0] reg_sel_t;

	localparam reg_sel_t REG_CTRL = 2'd0;
	localparam reg_sel_t REG_ORIGIN_ROW = 2'd1;
	localparam reg_sel_t REG_ORIGIN_COL = 2'd2;
	localparam reg_sel_t REG_COLOURS = 2'd3;

	// sprite layout in the frame buffer
	localparam int SPRITE_ROWS = 8;
	localparam int WORDS_PER_SPRITE_ROW = 2;

endpackage

//--- verilog/arena_regs.sv
/*
 * configuration registers: play enable, arena origin and player colours
 */
module arena_regs
	import arena_pkg::*;
	import trail_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  logic        reg_we,
	input  reg_sel_t    reg_sel,
	input  logic [15:0] reg_wdata,
	output logic        playing,
	output origin_row_t origin_row,
	output origin_col_t origin_col,
	output colour_t     blue_colour,
	output colour_t     red_colour
);

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			playing <= 1'b0;
			origin_row <= '0;
			origin_col <= '0;
			blue_colour <= '0;
			red_colour <= '0;
		end
		else if (reg_we)
		begin
			case (reg_sel)
				REG_CTRL: playing <= reg_wdata[0];
				REG_ORIGIN_ROW: origin_row <= reg_wdata[8:0];
				REG_ORIGIN_COL: origin_col <= reg_wdata[7:0];
				REG_COLOURS:
				begin
					// blue low nibble, red next
					blue_colour <= reg_wdata[3:0];
					red_colour <= reg_wdata[7:4];
				end
			endcase
		end
	end

endmodule

//--- verilog/trail_classifier.sv
/*
 * trail classifier: spots each player entering a new cell and picks the
 * tile kind from the heading at this move and at the one before
 */
module trail_classifier
	import arena_pkg::*;
	import trail_pkg::*;
(
	input  logic       Clk,
	input  logic       reset,
	input  logic       playing,
	input  cell_t      blue_x,
	input  cell_t      blue_y,
	input  cell_t      red_x,
	input  cell_t      red_y,
	input  dir_t       blue_dir,
	input  dir_t       red_dir,
	output logic       blue_move,
	output logic       red_move,
	output tile_kind_t blue_kind,
	output tile_kind_t red_kind,
	output cell_t      blue_cell_x,
	output cell_t      blue_cell_y,
	output cell_t      red_cell_x,
	output cell_t      red_cell_y
);

	logic started;
	dir_t blue_prev_dir;
	dir_t red_prev_dir;
	logic blue_step;
	logic red_step;

	function automatic tile_kind_t classify(input dir_t dir, input dir_t prev_dir);
		tile_kind_t kind;
		if (dir != prev_dir)
			kind = TILE_CORNER;
		else
		begin
			case (dir)
				DIR_UP, DIR_DOWN: kind = TILE_VERT;
				DIR_LEFT, DIR_RIGHT: kind = TILE_HORIZ;
				default: kind = TILE_NONE;
			endcase
		end
		return kind;
	endfunction

	// the registered move cell doubles as the previous cell
	assign blue_step = started && ((blue_x != blue_cell_x) || (blue_y != blue_cell_y));
	assign red_step = started && ((red_x != red_cell_x) || (red_y != red_cell_y));

	always_ff @(posedge Clk)
	begin
		if (reset || !playing)
		begin
			started <= 1'b0;
			blue_move <= 1'b0;
			red_move <= 1'b0;
		end
		else
		begin
			started <= 1'b1;
			blue_move <= blue_step;
			red_move <= red_step;
		end
	end

	// position and heading, captured on the first cycle of play and on each move
	always_ff @(posedge Clk)
	begin
		if (playing && (!started || blue_step))
		begin
			blue_cell_x <= blue_x;
			blue_cell_y <= blue_y;
			blue_prev_dir <= blue_dir;
			blue_kind <= classify(blue_dir, blue_prev_dir);
		end
		if (playing && (!started || red_step))
		begin
			red_cell_x <= red_x;
			red_cell_y <= red_y;
			red_prev_dir <= red_dir;
			red_kind <= classify(red_dir, red_prev_dir);
		end
	end

endmodule

//--- verilog/occupancy_map.sv
/*
 * occupancy map: one bit per arena cell, flags a crash when a player
 * enters a cell that already holds a trail
 */
module occupancy_map
	import arena_pkg::*;
(
	input  logic  Clk,
	input  logic  reset,
	input  logic  playing,
	input  logic  blue_move,
	input  logic  red_move,
	input  cell_t blue_cell_x,
	input  cell_t blue_cell_y,
	input  cell_t red_cell_x,
	input  cell_t red_cell_y,
	output logic  crash_blue,
	output logic  crash_red
);

	localparam int MAP_BITS = GRID_CELLS * GRID_CELLS;
	localparam int IDX_W = $clog2(MAP_BITS);

	logic [MAP_BITS-1:0] cells;
	logic [IDX_W-1:0] blue_idx;
	logic [IDX_W-1:0] red_idx;
	logic same_cell;

	// row major, y in the upper bits
	assign blue_idx = {blue_cell_y, blue_cell_x};
	assign red_idx = {red_cell_y, red_cell_x};

	// head-on into the same free cell takes out both players
	assign same_cell = blue_move && red_move && (blue_idx == red_idx);

	assign crash_blue = blue_move && (cells[blue_idx] || same_cell);
	assign crash_red = red_move && (cells[red_idx] || same_cell);

	always_ff @(posedge Clk)
	begin
		if (reset || !playing)
			cells <= '0;
		else
		begin
			if (blue_move)
				cells[blue_idx] <= 1'b1;
			if (red_move)
				cells[red_idx] <= 1'b1;
		end
	end

endmodule

//--- verilog/tile_sprite_rom.sv
/*
 * sprite ROM: returns one 8-pixel row mask of a trail tile
 */
module tile_sprite_rom
	import trail_pkg::*;
(
	input  tile_kind_t sprite_kind,
	input  logic [2:0] sprite_row,
	output logic [7:0] row_mask
);

	`include "tile_sprites.svh"

	always_comb
	begin
		case (sprite_kind)
			TILE_HORIZ: row_mask = SPRITE_HORIZ[sprite_row];
			TILE_VERT: row_mask = SPRITE_VERT[sprite_row];
			TILE_CORNER: row_mask = SPRITE_CORNER[sprite_row];
			// nothing to draw
			default: row_mask = '0;
		endcase
	end

endmodule

//--- verilog/trail_writer.sv
/*
 * trail writer: holds one pending tile per player and streams it into the
 * frame buffer as 16 words, blue burst first, one idle cycle, then red
 */
module trail_writer
	import arena_pkg::*;
	import trail_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  logic        playing,
	input  logic        blue_move,
	input  logic        red_move,
	input  tile_kind_t  blue_kind,
	input  tile_kind_t  red_kind,
	input  cell_t       blue_cell_x,
	input  cell_t       blue_cell_y,
	input  cell_t       red_cell_x,
	input  cell_t       red_cell_y,
	input  origin_row_t origin_row,
	input  origin_col_t origin_col,
	input  colour_t     blue_colour,
	input  colour_t     red_colour,
	input  logic [7:0]  row_mask,
	output tile_kind_t  sprite_kind,
	output logic [2:0]  sprite_row,
	output logic        fb_we,
	output fb_addr_t    fb_addr,
	output logic [15:0] fb_data
);

	localparam int BURST_WORDS = SPRITE_ROWS * WORDS_PER_SPRITE_ROW;
	localparam int IDX_W = $clog2(BURST_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BURST_WORDS - 1);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BLUE = 2'd1;
	localparam logic [1:0] ST_GAP = 2'd2;
	localparam logic [1:0] ST_RED = 2'd3;

	logic [1:0] state;
	logic [1:0] state_next;
	logic [IDX_W-1:0] word_idx;
	logic last_word;
	logic blue_pend;
	logic red_pend;
	tile_kind_t blue_slot_kind;
	tile_kind_t red_slot_kind;
	cell_t blue_slot_x;
	cell_t blue_slot_y;
	cell_t red_slot_x;
	cell_t red_slot_y;
	cell_t cur_x;
	cell_t cur_y;
	colour_t cur_colour;
	logic [PX_PER_WORD-1:0] half_mask;
	fb_addr_t line;
	fb_word_u fb_word;

	assign fb_we = (state == ST_BLUE) || (state == ST_RED);
	assign last_word = (word_idx == LAST_IDX);

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE:
				if (blue_pend)
					state_next = ST_BLUE;
				else if (red_pend)
					state_next = ST_RED;
			ST_BLUE:
				if (last_word)
					state_next = ST_GAP;
			ST_GAP:
				if (red_pend)
					state_next = ST_RED;
				else if (blue_pend)
					state_next = ST_BLUE;
				else
					state_next = ST_IDLE;
			ST_RED:
				if (last_word)
					state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (reset || !playing)
		begin
			state <= ST_IDLE;
			word_idx <= '0;
			blue_pend <= 1'b0;
			red_pend <= 1'b0;
		end
		else
		begin
			state <= state_next;
			word_idx <= fb_we ? word_idx + 1'b1 : '0;
			// a move in the last write cycle keeps the slot pending
			if (blue_move)
				blue_pend <= 1'b1;
			else if ((state == ST_BLUE) && last_word)
				blue_pend <= 1'b0;
			if (red_move)
				red_pend <= 1'b1;
			else if ((state == ST_RED) && last_word)
				red_pend <= 1'b0;
		end
	end

	// newer move overwrites a tile still waiting
	always_ff @(posedge Clk)
	begin
		if (blue_move)
		begin
			blue_slot_kind <= blue_kind;
			blue_slot_x <= blue_cell_x;
			blue_slot_y <= blue_cell_y;
		end
		if (red_move)
		begin
			red_slot_kind <= red_kind;
			red_slot_x <= red_cell_x;
			red_slot_y <= red_cell_y;
		end
	end

	always_comb
	begin
		cur_x = blue_slot_x;
		cur_y = blue_slot_y;
		cur_colour = blue_colour;
		sprite_kind = TILE_NONE;
		if (state == ST_BLUE)
			sprite_kind = blue_slot_kind;
		else if (state == ST_RED)
		begin
			cur_x = red_slot_x;
			cur_y = red_slot_y;
			cur_colour = red_colour;
			sprite_kind = red_slot_kind;
		end
	end

	// word index is {row, half}
	assign sprite_row = word_idx[IDX_W-1:1];
	assign half_mask = row_mask[word_idx[0] * PX_PER_WORD +: PX_PER_WORD];

	always_comb
	begin
		for (int i = 0; i < PX_PER_WORD; i++)
			fb_word.px[i] = half_mask[i] ? cur_colour : colour_t'(0);
	end

	assign fb_data = fb_word.raw;

	// screen line first, then the word within the line
	assign line = fb_addr_t'(origin_row) + fb_addr_t'(cur_y) * fb_addr_t'(CELL_PX)
		+ fb_addr_t'(sprite_row);
	assign fb_addr = line * fb_addr_t'(WORDS_PER_ROW) + fb_addr_t'(origin_col)
		+ fb_addr_t'(cur_x) * fb_addr_t'(WORDS_PER_SPRITE_ROW) + fb_addr_t'(word_idx[0]);

endmodule

//--- verilog/trail_unit.sv
/*
 * trail unit: configuration, move classification, occupancy and the
 * frame buffer writer of the light-cycle trails
 */
module trail_unit
	import arena_pkg::*;
	import trail_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  logic        reg_we,
	input  reg_sel_t    reg_sel,
	input  logic [15:0] reg_wdata,
	input  cell_t       blue_x,
	input  cell_t       blue_y,
	input  cell_t       red_x,
	input  cell_t       red_y,
	input  dir_t        blue_dir,
	input  dir_t        red_dir,
	output logic        crash_blue,
	output logic        crash_red,
	output logic        fb_we,
	output fb_addr_t    fb_addr,
	output logic [15:0] fb_data
);

	logic playing;
	origin_row_t origin_row;
	origin_col_t origin_col;
	colour_t blue_colour;
	colour_t red_colour;
	logic blue_move;
	logic red_move;
	tile_kind_t blue_kind;
	tile_kind_t red_kind;
	cell_t blue_cell_x;
	cell_t blue_cell_y;
	cell_t red_cell_x;
	cell_t red_cell_y;
	tile_kind_t sprite_kind;
	logic [2:0] sprite_row;
	logic [7:0] row_mask;

	arena_regs u_regs (
		.Clk(Clk), .reset(reset), .reg_we(reg_we), .reg_sel(reg_sel),
		.reg_wdata(reg_wdata), .playing(playing), .origin_row(origin_row),
		.origin_col(origin_col), .blue_colour(blue_colour), .red_colour(red_colour)
	);

	trail_classifier u_classifier (
		.Clk(Clk), .reset(reset), .playing(playing),
		.blue_x(blue_x), .blue_y(blue_y), .red_x(red_x), .red_y(red_y),
		.blue_dir(blue_dir), .red_dir(red_dir),
		.blue_move(blue_move), .red_move(red_move),
		.blue_kind(blue_kind), .red_kind(red_kind),
		.blue_cell_x(blue_cell_x), .blue_cell_y(blue_cell_y),
		.red_cell_x(red_cell_x), .red_cell_y(red_cell_y)
	);

	occupancy_map u_map (
		.Clk(Clk), .reset(reset), .playing(playing),
		.blue_move(blue_move), .red_move(red_move),
		.blue_cell_x(blue_cell_x), .blue_cell_y(blue_cell_y),
		.red_cell_x(red_cell_x), .red_cell_y(red_cell_y),
		.crash_blue(crash_blue), .crash_red(crash_red)
	);

	tile_sprite_rom u_rom (
		.sprite_kind(sprite_kind), .sprite_row(sprite_row), .row_mask(row_mask)
	);

	trail_writer u_writer (
		.Clk(Clk), .reset(reset), .playing(playing),
		.blue_move(blue_move), .red_move(red_move),
		.blue_kind(blue_kind), .red_kind(red_kind),
		.blue_cell_x(blue_cell_x), .blue_cell_y(blue_cell_y),
		.red_cell_x(red_cell_x), .red_cell_y(red_cell_y),
		.origin_row(origin_row), .origin_col(origin_col),
		.blue_colour(blue_colour), .red_colour(red_colour), .row_mask(row_mask),
		.sprite_kind(sprite_kind), .sprite_row(sprite_row),
		.fb_we(fb_we), .fb_addr(fb_addr), .fb_data(fb_data)
	);

endmodule

//--- tests/trail_unit_sva.sv
/*
 * bound checks on the trail unit: frame buffer write enable, write address
 * range and crash strobe length
 */
module trail_unit_sva
	import arena_pkg::*;
(
	input  logic     Clk,
	input  logic     reset,
	input  logic     playing,
	input  logic     fb_we,
	input  fb_addr_t fb_addr,
	input  logic     crash_blue,
	input  logic     crash_red
);

	timeunit 1ns;
	timeprecision 100ps;

	// 640x480 pixels at four pixels per word
	localparam int FB_WORDS = 76800;

	a_we_quiet: assert property (@(posedge Clk) (reset || !playing) |-> !fb_we)
		else $error("frame buffer written during reset or outside play");

	a_blue_crash_pulse: assert property (@(posedge Clk) disable iff (reset)
		crash_blue |=> !crash_blue)
		else $error("blue crash strobe held for two cycles");

	a_red_crash_pulse: assert property (@(posedge Clk) disable iff (reset)
		crash_red |=> !crash_red)
		else $error("red crash strobe held for two cycles");

	a_addr_range: assert property (@(posedge Clk) fb_we |-> (fb_addr < FB_WORDS))
		else $error("frame buffer address outside the screen");

endmodule

bind trail_unit trail_unit_sva u_sva (
	.Clk(Clk), .reset(reset), .playing(playing), .fb_we(fb_we), .fb_addr(fb_addr),
	.crash_blue(crash_blue), .crash_red(crash_red)
);

//--- tests/trail_unit_tb.sv
/*
 * trail unit testbench
 * drives random two-player walks and checks them against a model of the
 * tile writes and crashes
 */
module trail_unit_tb
	import arena_pkg::*;
	import trail_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// the ROM may already have pulled the table into this compile unit
	`undef TILE_SPRITES_SVH
	`include "tile_sprites.svh"

	localparam int ROUNDS = 40;
	localparam int MIN_GAP = 44;
	localparam int MAX_GAP = 60;
	localparam int BURST = SPRITE_ROWS * WORDS_PER_SPRITE_ROW;
	localparam longint WATCHDOG_NS = longint'((2 * ROUNDS * (MAX_GAP + 4) + 600) * 40);

	typedef struct {
		int cyc;
		tile_kind_t kind;
		cell_t x;
		cell_t y;
		colour_t colour;
	} tile_t;

	logic Clk;
	logic reset;
	logic reg_we;
	reg_sel_t reg_sel;
	logic [15:0] reg_wdata;
	cell_t blue_x;
	cell_t blue_y;
	cell_t red_x;
	cell_t red_y;
	dir_t blue_dir;
	dir_t red_dir;
	logic crash_blue;
	logic crash_red;
	logic fb_we;
	fb_addr_t fb_addr;
	logic [15:0] fb_data;

	int cycle = 0;
	tile_t blue_q[$];
	tile_t red_q[$];
	tile_t cur_tile;
	int burst_idx = 0;
	int last_write = -2;
	bit crash_b_at[int];
	bit crash_r_at[int];
	logic [GRID_CELLS*GRID_CELLS-1:0] occ_map;
	int used_cells[$];
	origin_row_t orow;
	origin_col_t ocol;
	colour_t bcol;
	colour_t rcol;
	dir_t b_prev;
	dir_t r_prev;

	trail_unit uut (
		.Clk(Clk), .reset(reset), .reg_we(reg_we), .reg_sel(reg_sel),
		.reg_wdata(reg_wdata), .blue_x(blue_x), .blue_y(blue_y),
		.red_x(red_x), .red_y(red_y), .blue_dir(blue_dir), .red_dir(red_dir),
		.crash_blue(crash_blue), .crash_red(crash_red),
		.fb_we(fb_we), .fb_addr(fb_addr), .fb_data(fb_data)
	);

	initial
	begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	always @(posedge Clk)
		cycle <= cycle + 1;

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("Test failed");
		$fatal(1, "timeout");
	end

	task automatic mismatch(input string msg);
		$display("MISMATCH at %0d ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "first mismatch");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_fb_write(input fb_addr_t exp_addr, input fb_word_u exp_word);
		if (fb_addr !== exp_addr || fb_data !== exp_word.raw)
			mismatch($sformatf("fb write addr %0d data %h, expected addr %0d data %h",
				fb_addr, fb_data, exp_addr, exp_word.raw));
	endtask

	task automatic check_crash(input bit is_red, input logic exp_bit);
		logic got;
		got = is_red ? crash_red : crash_blue;
		if (got !== exp_bit)
			mismatch($sformatf("%s crash is %b, expected %b",
				is_red ? "red" : "blue", got, exp_bit));
	endtask

	function automatic logic [7:0] sprite_mask(input tile_kind_t kind, input int row);
		logic [7:0] mask;
		case (kind)
			TILE_HORIZ: mask = SPRITE_HORIZ[row];
			TILE_VERT: mask = SPRITE_VERT[row];
			TILE_CORNER: mask = SPRITE_CORNER[row];
			default: mask = 8'h00;
		endcase
		return mask;
	endfunction

	// rows in order, left half of each row first
	function automatic fb_word_u tile_word(input tile_t t, input int idx);
		fb_word_u w;
		logic [7:0] mask;
		int half;
		mask = sprite_mask(t.kind, idx / 2);
		half = idx % 2;
		for (int i = 0; i < PX_PER_WORD; i++)
			w.px[i] = mask[half * PX_PER_WORD + i] ? t.colour : 4'h0;
		return w;
	endfunction

	function automatic fb_addr_t tile_addr(input tile_t t, input int idx);
		int a;
		a = (int'(orow) + int'(t.y) * CELL_PX + idx / 2) * WORDS_PER_ROW
			+ int'(ocol) + int'(t.x) * 2 + idx % 2;
		return fb_addr_t'(a);
	endfunction

	function automatic tile_kind_t expected_kind(input dir_t d, input dir_t prev);
		if (d != prev)
			return TILE_CORNER;
		return (d == DIR_UP || d == DIR_DOWN) ? TILE_VERT : TILE_HORIZ;
	endfunction

	// outputs settle long before the falling edge
	always @(negedge Clk)
	begin
		if (!reset)
		begin
			check_crash(1'b0, crash_b_at.exists(cycle) ? crash_b_at[cycle] : 1'b0);
			check_crash(1'b1, crash_r_at.exists(cycle) ? crash_r_at[cycle] : 1'b0);
			if (fb_we)
			begin
				if (burst_idx == 0)
				begin
					if (cycle == last_write + 1)
						abort_run("write burst started with no idle cycle before it");
					// a slot is seen by the FSM one cycle after the move strobe
					if (blue_q.size() > 0 && blue_q[0].cyc <= cycle - 2)
						cur_tile = blue_q.pop_front();
					else if (red_q.size() > 0 && red_q[0].cyc <= cycle - 2)
						cur_tile = red_q.pop_front();
					else
						abort_run("frame buffer write with no tile pending");
				end
				check_fb_write(tile_addr(cur_tile, burst_idx), tile_word(cur_tile, burst_idx));
				last_write = cycle;
				burst_idx = (burst_idx == BURST - 1) ? 0 : burst_idx + 1;
			end
			else if (burst_idx != 0)
				abort_run("write burst stopped before its last word");
		end
	end

	task automatic next_cycle;
		@(posedge Clk);
		#2;
	endtask

	task automatic write_reg(input reg_sel_t sel, input logic [15:0] data);
		next_cycle();
		reg_we = 1'b1;
		reg_sel = sel;
		reg_wdata = data;
		next_cycle();
		reg_we = 1'b0;
	endtask

	task automatic start_play;
		write_reg(REG_CTRL, 16'h0001);
		// the classifier captures positions on its first cycle
		repeat (4) next_cycle();
		b_prev = blue_dir;
		r_prev = red_dir;
	endtask

	task automatic stop_play;
		write_reg(REG_CTRL, 16'h0000);
		repeat (3) next_cycle();
		occ_map = '0;
		// players respawn elsewhere while the game is stopped
		blue_x = cell_t'(blue_x + 5'd7);
		red_y = cell_t'(red_y + 5'd9);
		red_dir = DIR_UP;
	endtask

	task automatic pick_step(input bit is_red, input bit revisit,
		output cell_t nx, output cell_t ny, output dir_t nd);
		cell_t cx;
		cell_t cy;
		int idx;
		cx = is_red ? red_x : blue_x;
		cy = is_red ? red_y : blue_y;
		nd = is_red ? red_dir : blue_dir;
		if ($urandom_range(2, 0) == 0)
			nd = dir_t'($urandom_range(3, 0));
		nx = cx;
		ny = cy;
		case (nd)
			DIR_UP: ny = cell_t'(cy - 1);
			DIR_DOWN: ny = cell_t'(cy + 1);
			DIR_LEFT: nx = cell_t'(cx - 1);
			default: nx = cell_t'(cx + 1);
		endcase
		if (revisit && used_cells.size() > 0)
		begin
			idx = used_cells[$urandom_range(used_cells.size() - 1, 0)];
			if (idx != int'({cy, cx}))
			begin
				nx = cell_t'(idx % GRID_CELLS);
				ny = cell_t'(idx / GRID_CELLS);
			end
		end
	endtask

	// drive the steps and log what the DUT must do one cycle later
	task automatic apply_moves(input bit do_b, input bit do_r,
		input cell_t bx, input cell_t by, input dir_t bd,
		input cell_t rx, input cell_t ry, input dir_t rd);
		int s;
		int bi;
		int ri;
		bit same;
		tile_t t;
		s = cycle + 1;
		bi = int'({by, bx});
		ri = int'({ry, rx});
		same = do_b && do_r && (bi == ri);
		if (do_b)
		begin
			crash_b_at[s] = occ_map[bi] || same;
			t = '{s, expected_kind(bd, b_prev), bx, by, bcol};
			blue_q.push_back(t);
			b_prev = bd;
			blue_x = bx;
			blue_y = by;
			blue_dir = bd;
		end
		if (do_r)
		begin
			crash_r_at[s] = occ_map[ri] || same;
			t = '{s, expected_kind(rd, r_prev), rx, ry, rcol};
			red_q.push_back(t);
			r_prev = rd;
			red_x = rx;
			red_y = ry;
			red_dir = rd;
		end
		if (do_b)
		begin
			occ_map[bi] = 1'b1;
			used_cells.push_back(bi);
		end
		if (do_r)
		begin
			occ_map[ri] = 1'b1;
			used_cells.push_back(ri);
		end
	endtask

	task automatic run_rounds(input int n, input bit revisit_first);
		int mode;
		int offset;
		bit revisit;
		cell_t bx;
		cell_t by;
		cell_t rx;
		cell_t ry;
		dir_t bd;
		dir_t rd;
		for (int r = 0; r < n; r++)
		begin
			repeat ($urandom_range(MAX_GAP, MIN_GAP)) next_cycle();
			mode = $urandom_range(2, 0);
			revisit = ($urandom_range(7, 0) == 0) || (revisit_first && r == 0);
			pick_step(1'b0, revisit, bx, by, bd);
			pick_step(1'b1, revisit, rx, ry, rd);
			if (mode == 0)
				apply_moves(1'b1, 1'b0, bx, by, bd, rx, ry, rd);
			else if (mode == 1)
				apply_moves(1'b0, 1'b1, bx, by, bd, rx, ry, rd);
			else
			begin
				offset = ($urandom_range(1, 0) == 0) ? 0 : $urandom_range(3, 1);
				// head-on into the cell blue is taking
				if (offset == 0 && $urandom_range(4, 0) == 0 && {red_y, red_x} != {by, bx})
				begin
					rx = bx;
					ry = by;
				end
				if (offset == 0)
					apply_moves(1'b1, 1'b1, bx, by, bd, rx, ry, rd);
				else
				begin
					apply_moves(1'b1, 1'b0, bx, by, bd, rx, ry, rd);
					repeat (offset) next_cycle();
					apply_moves(1'b0, 1'b1, bx, by, bd, rx, ry, rd);
				end
			end
		end
		repeat (80) next_cycle();
	endtask

	initial
	begin
		reset = 1'b1;
		reg_we = 1'b0;
		reg_sel = REG_CTRL;
		reg_wdata = 16'h0000;
		blue_x = 5'd2;
		blue_y = 5'd2;
		red_x = 5'd20;
		red_y = 5'd20;
		blue_dir = DIR_RIGHT;
		red_dir = DIR_LEFT;
		occ_map = '0;
		void'($urandom(32'h0590_11db));
		repeat (5) @(posedge Clk);
		#2;
		reset = 1'b0;

		// keep the 256x256 arena on screen
		orow = origin_row_t'($urandom_range(224, 0));
		ocol = origin_col_t'($urandom_range(96, 0));
		bcol = colour_t'($urandom_range(15, 1));
		rcol = colour_t'($urandom_range(15, 1));
		write_reg(REG_ORIGIN_ROW, 16'(orow));
		write_reg(REG_ORIGIN_COL, 16'(ocol));
		write_reg(REG_COLOURS, {8'h00, rcol, bcol});

		start_play();
		run_rounds(ROUNDS, 1'b0);
		if (blue_q.size() != 0 || red_q.size() != 0)
			abort_run("tiles still unwritten before play was stopped");
		stop_play();
		// the map starts empty again, so old cells must not crash
		start_play();
		run_rounds(ROUNDS, 1'b1);

		if (blue_q.size() == 0 && red_q.size() == 0 && burst_idx == 0)
		begin
			$display("Test completed successfully");
			$finish;
		end
		else
		begin
			$display("expected tile writes never appeared");
			$display("Test failed");
			$fatal(1, "writes missing");
		end
	end

endmodule

//--- filelist.f
+incdir+include
verilog/arena_pkg.sv
verilog/trail_pkg.sv
verilog/arena_regs.sv
verilog/trail_classifier.sv
verilog/occupancy_map.sv
verilog/tile_sprite_rom.sv
verilog/trail_writer.sv
verilog/trail_unit.sv
tests/trail_unit_sva.sv
tests/trail_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the trail unit simulation, exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module trail_unit_tb --Mdir obj_dir -o trail_sim &&
./obj_dir/trail_sim || { echo "simulation failed"; exit 1; }
